// File: hdl/delay_timer.sv
module delay_timer (
    input  logic                        ace_aclk,
    input  logic                        ace_aresetn,
    input  logic                        i_start,
    input  logic [devil_pkg::REG_W-1:0] i_delay,
    output logic                        o_elapsed
);

    import devil_pkg::*;

    logic               r_running;
    logic [TIMER_W-1:0] r_count;
    logic [TIMER_W-1:0] r_target;

    // Target in clock cycles
    always_ff @(posedge ace_aclk)
    begin
        if (i_start)
        begin
            r_target <= TIMER_W'(i_delay) * TIMER_W'(CYCLES_PER_UNIT);
        end
    end

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            r_running <= 1'b0;
            r_count   <= '0;
        end
        else if (i_start)
        begin
            r_running <= 1'b1;
            r_count   <= '0;
        end
        else if (o_elapsed)
        begin
            r_running <= 1'b0;
        end
        else if (r_running)
        begin
            r_count <= r_count + 1'b1;
        end
    end

    // Zero delay fires on the cycle after start
    assign o_elapsed = r_running && (r_count == r_target);

    // Counter parks at its target, so each start gives one pulse
    a_count_bound: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        r_running |-> (r_count <= r_target))
        else $error("delay count ran past its target");

endmodule

// File: hdl/devil_fsm.sv
module devil_fsm (
    input  logic             ace_aclk,
    input  logic             ace_aresetn,
    input  logic             i_acvalid,
    input  logic             i_crready,
    input  devil_pkg::ctrl_t i_ctrl,
    input  logic             i_pass,
    input  logic             i_held,
    input  logic             i_elapsed,
    output logic             o_acready,
    output logic             o_accept,
    output logic             o_dummy_go,
    output logic             o_first_go,
    output logic             o_second_go,
    output logic             o_clear,
    output logic             o_timer_start,
    output logic             o_osh_done,
    output logic             o_end,
    output logic             o_reply_pulse
);

    import devil_pkg::*;

    devil_state_t r_state;
    // End state taken once the crafted reply is out
    devil_state_t r_return;

    ////////////////////////////////////////
    // Handshake and commands
    ////////////////////////////////////////

    assign o_acready = (r_state == IDLE);
    assign o_accept  = o_acready && i_acvalid && i_ctrl.enable && !o_end;

    assign o_dummy_go    = (r_state == DUMMY_REPLY) && i_crready;
    assign o_first_go    = (r_state == RESPONSE);
    assign o_timer_start = (r_state == RESPONSE) && i_held;
    assign o_second_go   = (r_state == DELAY) && i_elapsed;
    assign o_clear       = (r_state == END_OP) || (r_state == END_REPLY);

    ////////////////////////////////////////
    // State sequence
    ////////////////////////////////////////

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            r_state       <= IDLE;
            r_return      <= END_REPLY;
            o_osh_done    <= 1'b0;
            o_end         <= 1'b0;
            o_reply_pulse <= 1'b0;
        end
        else
        begin
            o_reply_pulse <= 1'b0;
            case (r_state)
                IDLE:
                begin
                    if (o_accept)
                    begin
                        r_state <= FILTER;
                    end
                    // Rearm one-shot once software drops its enable
                    if (o_osh_done && !i_ctrl.osh_en)
                    begin
                        o_osh_done <= 1'b0;
                    end
                    // Core must be disabled before it runs again
                    if (o_end && !i_ctrl.enable)
                    begin
                        o_end <= 1'b0;
                    end
                end
                FILTER:
                begin
                    r_state <= i_pass ? FUNCTION : DUMMY_REPLY;
                end
                FUNCTION:
                begin
                    if (i_ctrl.func == FUNC_OSH && i_ctrl.osh_en && !o_osh_done)
                    begin
                        r_state <= ONE_SHOT;
                    end
                    else if (i_ctrl.func == FUNC_CON && i_ctrl.con_en)
                    begin
                        r_state <= CONTINUOUS;
                    end
                    else
                    begin
                        r_state <= DUMMY_REPLY;
                    end
                end
                DUMMY_REPLY:
                begin
                    if (i_crready)
                    begin
                        r_state <= END_REPLY;
                    end
                end
                ONE_SHOT:
                begin
                    if (i_crready)
                    begin
                        o_osh_done <= 1'b1;
                        r_return   <= END_OP;
                        r_state    <= RESPONSE;
                    end
                end
                CONTINUOUS:
                begin
                    // Enable low here makes this the last reply
                    if (i_crready)
                    begin
                        r_return <= i_ctrl.con_en ? END_REPLY : END_OP;
                        r_state  <= RESPONSE;
                    end
                end
                RESPONSE:
                begin
                    r_state <= i_held ? DELAY : r_return;
                end
                DELAY:
                begin
                    if (i_elapsed)
                    begin
                        r_state <= r_return;
                    end
                end
                END_OP:
                begin
                    o_end         <= 1'b1;
                    o_reply_pulse <= 1'b1;
                    r_state       <= IDLE;
                end
                END_REPLY:
                begin
                    o_reply_pulse <= 1'b1;
                    r_state       <= IDLE;
                end
                default:
                begin
                    r_state <= IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // AC channel stays closed until the reply has finished
    a_acready_reopen: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        $rose(o_acready) |-> o_reply_pulse)
        else $error("acready reopened before the reply ended");

endmodule

// File: hdl/devil_pkg.sv
package devil_pkg;

    ////////////////////////////////////////
    // Widths and timing
    ////////////////////////////////////////

    // Snoop address width on the AC channel
    localparam int ADDR_W = 44;
    // Address bits used by the window filter
    localparam int CMP_W = 32;
    localparam int REG_W = 32;
    // 1 us at 150 MHz
    localparam int CYCLES_PER_UNIT = 150;
    // Room for REG_W delay units times CYCLES_PER_UNIT
    localparam int TIMER_W = REG_W + 8;

    ////////////////////////////////////////
    // Function and test codes
    ////////////////////////////////////////

    localparam logic [3:0] FUNC_OSH = 4'b0000;
    localparam logic [3:0] FUNC_CON = 4'b0001;

    localparam logic [3:0] TEST_FUZZ        = 4'b0000;
    localparam logic [3:0] TEST_DLY_CRVALID = 4'b0001;
    localparam logic [3:0] TEST_DLY_CDVALID = 4'b0010;
    localparam logic [3:0] TEST_DLY_CDLAST  = 4'b0011;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    // Control word, enable sits in bit 0
    typedef struct packed {
        logic [13:0] spare;
        logic        con_en;
        logic        osh_en;
        logic        addr_flt_en;
        logic        snoop_flt_en;
        logic [4:0]  crresp;
        logic [3:0]  func;
        logic [3:0]  test;
        logic        enable;
    } ctrl_t;

    typedef struct packed {
        logic [3:0]        acsnoop;
        logic [ADDR_W-1:0] addr;
    } snoop_req_t;

    typedef struct packed {
        logic       crvalid;
        logic       cdvalid;
        logic       cdlast;
        logic [4:0] crresp;
    } reply_t;

    typedef enum logic [3:0] {
        IDLE,
        FILTER,
        FUNCTION,
        DUMMY_REPLY,
        ONE_SHOT,
        CONTINUOUS,
        RESPONSE,
        DELAY,
        END_OP,
        END_REPLY
    } devil_state_t;

endpackage

// File: hdl/devil_top.sv
module devil_top (
    input  logic                        ace_aclk,
    input  logic                        ace_aresetn,
    // AC channel
    input  logic                        i_acvalid,
    output logic                        o_acready,
    input  devil_pkg::snoop_req_t       i_ac,
    // Control registers
    input  devil_pkg::ctrl_t            i_ctrl,
    input  logic [devil_pkg::REG_W-1:0] i_delay,
    input  logic [3:0]                  i_acsnoop_match,
    input  logic [devil_pkg::REG_W-1:0] i_base_addr,
    input  logic [devil_pkg::REG_W-1:0] i_addr_size,
    // CR and CD side
    input  logic                        i_crready,
    output logic                        o_crvalid,
    output logic                        o_cdvalid,
    output logic                        o_cdlast,
    output logic [4:0]                  o_crresp,
    // Status
    output logic                        o_reply,
    output logic                        o_end,
    output logic                        o_osh_done
);

    import devil_pkg::*;

    logic   w_accept;
    logic   w_pass;
    logic   w_held;
    logic   w_elapsed;
    logic   w_dummy_go;
    logic   w_first_go;
    logic   w_second_go;
    logic   w_clear;
    logic   w_timer_start;
    reply_t w_reply;

    snoop_filter u_snoop_filter (
        .ace_aclk        (ace_aclk),
        .ace_aresetn     (ace_aresetn),
        .i_accept        (w_accept),
        .i_ac            (i_ac),
        .i_ctrl          (i_ctrl),
        .i_acsnoop_match (i_acsnoop_match),
        .i_base_addr     (i_base_addr),
        .i_addr_size     (i_addr_size),
        .o_pass          (w_pass)
    );

    devil_fsm u_devil_fsm (
        .ace_aclk      (ace_aclk),
        .ace_aresetn   (ace_aresetn),
        .i_acvalid     (i_acvalid),
        .i_crready     (i_crready),
        .i_ctrl        (i_ctrl),
        .i_pass        (w_pass),
        .i_held        (w_held),
        .i_elapsed     (w_elapsed),
        .o_acready     (o_acready),
        .o_accept      (w_accept),
        .o_dummy_go    (w_dummy_go),
        .o_first_go    (w_first_go),
        .o_second_go   (w_second_go),
        .o_clear       (w_clear),
        .o_timer_start (w_timer_start),
        .o_osh_done    (o_osh_done),
        .o_end         (o_end),
        .o_reply_pulse (o_reply)
    );

    delay_timer u_delay_timer (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_start     (w_timer_start),
        .i_delay     (i_delay),
        .o_elapsed   (w_elapsed)
    );

    reply_driver u_reply_driver (
        .ace_aclk    (ace_aclk),
        .ace_aresetn (ace_aresetn),
        .i_dummy_go  (w_dummy_go),
        .i_first_go  (w_first_go),
        .i_second_go (w_second_go),
        .i_clear     (w_clear),
        .i_ctrl      (i_ctrl),
        .o_held      (w_held),
        .o_reply     (w_reply)
    );

    assign o_crvalid = w_reply.crvalid;
    assign o_cdvalid = w_reply.cdvalid;
    assign o_cdlast  = w_reply.cdlast;
    assign o_crresp  = w_reply.crresp;

endmodule

// File: hdl/reply_driver.sv
module reply_driver (
    input  logic               ace_aclk,
    input  logic               ace_aresetn,
    input  logic               i_dummy_go,
    input  logic               i_first_go,
    input  logic               i_second_go,
    input  logic               i_clear,
    input  devil_pkg::ctrl_t   i_ctrl,
    output logic               o_held,
    output devil_pkg::reply_t  o_reply
);

    import devil_pkg::*;

    logic [3:0] r_test;
    logic       r_pending;

    function automatic logic is_delay_test(input logic [3:0] test);
        return (test == TEST_DLY_CRVALID)
            || (test == TEST_DLY_CDVALID)
            || (test == TEST_DLY_CDLAST);
    endfunction

    // Decoded live during the first phase, latched afterwards
    assign o_held = i_first_go ? is_delay_test(i_ctrl.test) : r_pending;

    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            o_reply   <= '0;
            r_test    <= TEST_FUZZ;
            r_pending <= 1'b0;
        end
        else if (i_clear)
        begin
            o_reply   <= '0;
            r_pending <= 1'b0;
        end
        else if (i_dummy_go)
        begin
            o_reply.crvalid <= 1'b1;
            o_reply.crresp  <= '0;
        end
        else if (i_first_go)
        begin
            o_reply.crresp <= i_ctrl.crresp;
            r_test         <= i_ctrl.test;
            r_pending      <= is_delay_test(i_ctrl.test);
            // Unknown codes leave all lines low
            case (i_ctrl.test)
                TEST_FUZZ:        o_reply[7:5] <= 3'b111;
                TEST_DLY_CRVALID: o_reply[7:5] <= 3'b011;
                TEST_DLY_CDVALID: o_reply[7:5] <= 3'b101;
                TEST_DLY_CDLAST:  o_reply[7:5] <= 3'b110;
                default:          o_reply[7:5] <= 3'b000;
            endcase
        end
        else if (i_second_go && r_pending)
        begin
            r_pending <= 1'b0;
            case (r_test)
                TEST_DLY_CRVALID: o_reply.crvalid <= 1'b1;
                TEST_DLY_CDVALID: o_reply.cdvalid <= 1'b1;
                TEST_DLY_CDLAST:  o_reply.cdlast  <= 1'b1;
                default:          o_reply.crvalid <= o_reply.crvalid;
            endcase
        end
    end

    a_cdlast_order: assert property (@(posedge ace_aclk) disable iff (!ace_aresetn)
        $rose(o_reply.cdlast) |-> o_reply.cdvalid || (r_test == TEST_DLY_CDVALID))
        else $error("cdlast rose ahead of cdvalid");

endmodule

// File: hdl/snoop_filter.sv
module snoop_filter (
    input  logic                 ace_aclk,
    input  logic                 ace_aresetn,
    input  logic                 i_accept,
    input  devil_pkg::snoop_req_t i_ac,
    input  devil_pkg::ctrl_t     i_ctrl,
    input  logic [3:0]           i_acsnoop_match,
    input  logic [devil_pkg::REG_W-1:0] i_base_addr,
    input  logic [devil_pkg::REG_W-1:0] i_addr_size,
    output logic                 o_pass
);

    import devil_pkg::*;

    snoop_req_t       r_req;
    logic             r_valid;
    logic             w_snoop_hit;
    logic             w_addr_hit;
    logic [CMP_W:0]   w_win_end;
    logic [CMP_W-1:0] w_addr_low;

    // Request register, loaded on the handshake only
    always_ff @(posedge ace_aclk)
    begin
        if (i_accept)
        begin
            r_req <= i_ac;
        end
    end

    // Nothing to compare before the first accepted request
    always_ff @(posedge ace_aclk)
    begin
        if (!ace_aresetn)
        begin
            r_valid <= 1'b0;
        end
        else if (i_accept)
        begin
            r_valid <= 1'b1;
        end
    end

    assign w_snoop_hit = (r_req.acsnoop == i_acsnoop_match);

    // Window end kept one bit wider so base plus size cannot wrap
    assign w_addr_low = r_req.addr[CMP_W-1:0];
    assign w_win_end  = {1'b0, i_base_addr[CMP_W-1:0]} + {1'b0, i_addr_size[CMP_W-1:0]};
    assign w_addr_hit = (w_addr_low >= i_base_addr[CMP_W-1:0])
                     && ({1'b0, w_addr_low} < w_win_end);

    // Disabled filters always pass
    assign o_pass = r_valid
                 && (!i_ctrl.snoop_flt_en || w_snoop_hit)
                 && (!i_ctrl.addr_flt_en || w_addr_hit);

endmodule

// File: run.sh
#!/bin/sh
# Build and run with Verilator, pass only when the pass message is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module devil_tb -o devil_sim \
    && ./obj_dir/devil_sim | tee /dev/stderr | grep -q "Test OK" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: sim.f
+incdir+verif
hdl/devil_pkg.sv
hdl/snoop_filter.sv
hdl/devil_fsm.sv
hdl/delay_timer.sv
hdl/reply_driver.sv
hdl/devil_top.sv
verif/devil_tb.sv

// File: verif/devil_model.svh
`ifndef DEVIL_MODEL_SVH
`define DEVIL_MODEL_SVH

// Three-term xorshift on 32 bits
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Line masks are {crvalid, cdvalid, cdlast}
task automatic predict_reply(
    input  ctrl_t       c,
    input  logic [3:0]  match,
    input  logic [31:0] base,
    input  logic [31:0] size,
    input  snoop_req_t  req,
    input  logic        osh_done,
    output logic        target,
    output logic [4:0]  resp,
    output logic [2:0]  first,
    output logic [2:0]  held
);
    logic        snoop_ok;
    logic        addr_ok;
    logic        armed;
    logic [32:0] lo;
    logic [32:0] top;
    lo       = {1'b0, req.addr[31:0]};
    top      = {1'b0, base} + {1'b0, size};
    snoop_ok = !c.snoop_flt_en || (req.acsnoop == match);
    addr_ok  = !c.addr_flt_en || ((lo >= {1'b0, base}) && (lo < top));
    armed    = ((c.func == FUNC_OSH) && c.osh_en && !osh_done)
            || ((c.func == FUNC_CON) && c.con_en);
    target   = snoop_ok && addr_ok && armed;
    held     = 3'b000;
    if (c.test == TEST_DLY_CRVALID) held = 3'b100;
    if (c.test == TEST_DLY_CDVALID) held = 3'b010;
    if (c.test == TEST_DLY_CDLAST)  held = 3'b001;
    // Plain reply for everything that is not a target
    if (!target)
    begin
        held = 3'b000;
    end
    first = target ? (3'b111 & ~held) : 3'b100;
    resp  = target ? c.crresp : 5'd0;
endtask

`endif

// File: verif/devil_tb.sv
module devil_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import devil_pkg::*;

    `include "devil_model.svh"

    localparam int REPLY_WAIT  = 3 * CYCLES_PER_UNIT + 20;
    localparam int CYCLE_LIMIT = 400 * REPLY_WAIT;

    logic        ace_aclk;
    logic        ace_aresetn;
    logic        i_acvalid;
    logic        o_acready;
    snoop_req_t  i_ac;
    ctrl_t       i_ctrl;
    logic [31:0] i_delay;
    logic [3:0]  i_acsnoop_match;
    logic [31:0] i_base_addr;
    logic [31:0] i_addr_size;
    logic        i_crready;
    logic        o_crvalid;
    logic        o_cdvalid;
    logic        o_cdlast;
    logic [4:0]  o_crresp;
    logic        o_reply;
    logic        o_end;
    logic        o_osh_done;

    logic [31:0] rnd;
    logic [31:0] rnd_cr;
    logic        hold_cr;
    logic        model_osh_done;
    int          cycles;
    int          errors;
    int          rise_at[3];
    int          fall_at[3];
    int          reply_at;

    devil_top i_devil_top (.*);

    always #10 ace_aclk = ~ace_aclk;

    // Random back-pressure on the CR side, separate stream
    always @(posedge ace_aclk)
    begin
        rnd_cr = xorshift32(rnd_cr);
        i_crready <= hold_cr ? 1'b0 : rnd_cr[0];
    end

    always @(posedge ace_aclk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout after %0d cycles, %0d errors", cycles, errors);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic next_random(output logic [31:0] v);
        rnd = xorshift32(rnd);
        v   = rnd;
    endtask

    function automatic string line_name(input int i);
        return (i == 2) ? "o_crvalid" : ((i == 1) ? "o_cdvalid" : "o_cdlast");
    endfunction

    task automatic report_mismatch(input string name, input int got, input int exp);
        errors++;
        $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("t=%0t %s", $time, what);
    endtask

    task automatic setup(input ctrl_t c, input logic [3:0] m, input logic [31:0] b,
                         input logic [31:0] s, input logic [31:0] d);
        @(posedge ace_aclk);
        i_ctrl          <= c;
        i_acsnoop_match <= m;
        i_base_addr     <= b;
        i_addr_size     <= s;
        i_delay         <= d;
        // New settings are visible to the model from here on
        @(negedge ace_aclk);
    endtask

    task automatic send_request(input snoop_req_t req);
        @(posedge ace_aclk);
        i_acvalid <= 1'b1;
        i_ac      <= req;
        @(posedge ace_aclk);
        i_acvalid <= 1'b0;
    endtask

    // Record rise and fall cycles of each line until o_reply
    task automatic watch_reply(input logic [4:0] exp_resp);
        logic [2:0] prev;
        logic [2:0] cur;
        int         n;
        prev     = 3'b000;
        n        = 0;
        reply_at = -1;
        for (int i = 0; i < 3; i++)
        begin
            rise_at[i] = -1;
            fall_at[i] = -1;
        end
        while (reply_at < 0 && n < REPLY_WAIT)
        begin
            @(negedge ace_aclk);
            n++;
            cur = {o_crvalid, o_cdvalid, o_cdlast};
            for (int i = 0; i < 3; i++)
            begin
                if (cur[i] && !prev[i]) rise_at[i] = cycles;
                if (!cur[i] && prev[i]) fall_at[i] = cycles;
            end
            if (cur != 3'b000 && o_crresp != exp_resp)
                report_mismatch("o_crresp", int'(o_crresp), int'(exp_resp));
            if (o_reply) reply_at = cycles;
            prev = cur;
        end
        if (reply_at < 0) report_failure("o_reply never pulsed after a request");
    endtask

    task automatic check_reply(input logic [2:0] first, input logic [2:0] held,
                               input logic [31:0] delay);
        int t0;
        int h;
        int tend;
        t0 = -1;
        h  = -1;
        for (int i = 0; i < 3; i++)
        begin
            if (first[i]) t0 = rise_at[i];
            if (held[i]) h = i;
        end
        if (t0 < 0)
        begin
            report_failure("reply lines never rose");
            return;
        end
        for (int i = 0; i < 3; i++)
            if (first[i] && rise_at[i] != t0)
                report_mismatch({line_name(i), " rise"}, rise_at[i], t0);
        tend = t0 + 1;
        if (h >= 0)
        begin
            if (rise_at[h] < t0 + int'(delay) * CYCLES_PER_UNIT)
                report_mismatch({line_name(h), " held rise"}, rise_at[h],
                                t0 + int'(delay) * CYCLES_PER_UNIT);
            tend = rise_at[h] + 1;
        end
        for (int i = 0; i < 3; i++)
        begin
            if (first[i] || held[i])
            begin
                if (fall_at[i] != tend)
                    report_mismatch({line_name(i), " fall"}, fall_at[i], tend);
            end
            else if (rise_at[i] != -1)
                report_failure({line_name(i), " rose although the test never raises it"});
        end
        if (reply_at != tend) report_mismatch("o_reply cycle", reply_at, tend);
    endtask

    task automatic run_one(input snoop_req_t req);
        logic       target;
        logic [4:0] resp;
        logic [2:0] first;
        logic [2:0] held;
        predict_reply(i_ctrl, i_acsnoop_match, i_base_addr, i_addr_size, req,
                      model_osh_done, target, resp, first, held);
        send_request(req);
        watch_reply(resp);
        check_reply(first, held, i_delay);
        if (target && i_ctrl.func == FUNC_OSH) model_osh_done = 1'b1;
        if (o_osh_done != model_osh_done)
            report_mismatch("o_osh_done", int'(o_osh_done), int'(model_osh_done));
    endtask

    // While o_end is set, requests must be left unaccepted
    task automatic expect_blocked();
        @(posedge ace_aclk);
        i_acvalid <= 1'b1;
        repeat (6)
        begin
            @(negedge ace_aclk);
            if (!o_acready) report_failure("o_acready dropped while o_end was set");
            if (o_crvalid || o_reply) report_failure("request accepted while o_end was set");
        end
        @(posedge ace_aclk);
        i_acvalid <= 1'b0;
    endtask

    initial
    begin
        ctrl_t       c;
        snoop_req_t  req;
        logic [31:0] r;
        logic [31:0] r2;
        ace_aclk        = 1'b0;
        ace_aresetn     = 1'b0;
        i_acvalid       = 1'b0;
        i_ac            = '0;
        i_ctrl          = '0;
        i_delay         = '0;
        i_acsnoop_match = '0;
        i_base_addr     = '0;
        i_addr_size     = '0;
        i_crready       = 1'b0;
        hold_cr         = 1'b0;
        rnd             = 32'd66;
        rnd_cr          = xorshift32(32'd66);
        model_osh_done  = 1'b0;
        cycles          = 0;
        errors          = 0;
        repeat (16) @(posedge ace_aclk);
        ace_aresetn <= 1'b1;

        ////////////////////////////////////////
        // Reset values
        ////////////////////////////////////////
        @(negedge ace_aclk);
        if ({o_crvalid, o_cdvalid, o_cdlast, o_reply, o_end, o_osh_done} != 6'b0)
            report_failure("reply or status output high after reset");
        if (!o_acready) report_mismatch("o_acready", 0, 1);

        // Continuous fuzzing, no filters
        c = '0;
        c.enable = 1'b1;
        c.func   = FUNC_CON;
        c.con_en = 1'b1;
        c.test   = TEST_FUZZ;
        for (int k = 0; k < 60; k++)
        begin
            next_random(r);
            c.crresp = r[4:0];
            setup(c, 4'd0, 32'd0, 32'd0, 32'd0);
            next_random(r);
            next_random(r2);
            req = {r2[3:0], r2[15:4], r};
            run_one(req);
        end

        ////////////////////////////////////////
        // Random filters, tests and delays
        ////////////////////////////////////////
        for (int k = 0; k < 200; k++)
        begin
            next_random(r);
            c.snoop_flt_en = r[0];
            c.addr_flt_en  = r[1];
            c.test         = {2'b00, r[3:2]};
            c.crresp       = r[8:4];
            next_random(r2);
            setup(c, r[12:9], r2, {20'd0, r[27:16]}, 32'(r[31:30] % 2'd3));
            next_random(r);
            req.acsnoop   = r[0] ? i_acsnoop_match : r[7:4];
            req.addr[43:32] = r[19:8];
            next_random(r2);
            if (r[1] && i_addr_size != 0)
                req.addr[31:0] = i_base_addr + (r2 % i_addr_size);
            else
                req.addr[31:0] = r2;
            run_one(req);
        end

        ////////////////////////////////////////
        // One-shot function
        ////////////////////////////////////////
        c = '0;
        c.enable = 1'b1;
        c.func   = FUNC_OSH;
        c.osh_en = 1'b1;
        c.crresp = 5'h15;
        setup(c, 4'd0, 32'd0, 32'd0, 32'd0);
        run_one(req);
        if (!o_end) report_mismatch("o_end", 0, 1);
        expect_blocked();
        c.enable = 1'b0;
        setup(c, 4'd0, 32'd0, 32'd0, 32'd0);
        repeat (2) @(negedge ace_aclk);
        if (o_end) report_mismatch("o_end", 1, 0);
        c.enable = 1'b1;
        setup(c, 4'd0, 32'd0, 32'd0, 32'd0);
        // Still done, so the next request gets a plain reply
        run_one(req);
        c.osh_en = 1'b0;
        setup(c, 4'd0, 32'd0, 32'd0, 32'd0);
        repeat (2) @(negedge ace_aclk);
        model_osh_done = 1'b0;
        if (o_osh_done) report_mismatch("o_osh_done", 1, 0);

        // Continuous end, enable dropped while the FSM waits for crready
        c.func   = FUNC_CON;
        c.con_en = 1'b1;
        c.crresp = 5'h0b;
        setup(c, 4'd0, 32'd0, 32'd0, 32'd0);
        @(posedge ace_aclk);
        hold_cr <= 1'b1;
        repeat (2) @(posedge ace_aclk);
        send_request(req);
        repeat (6) @(posedge ace_aclk);
        c.con_en = 1'b0;
        i_ctrl <= c;
        @(posedge ace_aclk);
        hold_cr <= 1'b0;
        watch_reply(5'h0b);
        check_reply(3'b111, 3'b000, 32'd0);
        if (!o_end) report_mismatch("o_end", 0, 1);
        expect_blocked();

        $display("Closing report: %0d errors, %0d cycles", errors, cycles);
        if (errors == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
